// File: tcp_srv_cfg.svh
`ifndef TCP_SRV_CFG_SVH
`define TCP_SRV_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// header field widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define TCP_PORT_W 16
`define TCP_SEQ_W  32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone register map, byte addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define WB_DAT_W 32
`define WB_ADR_W 4

`define REG_CTRL     4'h0
`define REG_LOC_PORT 4'h4
`define REG_ISN      4'h8
`define REG_STATUS   4'hC  // read only.

// control register bits.
`define CTRL_LISTEN_BIT    0
`define CTRL_FORCE_DCN_BIT 1

`endif

// File: tcp_srv_pkg.sv
`default_nettype none

`include "tcp_srv_cfg.svh"

package tcp_srv_pkg;

  typedef logic [`TCP_PORT_W-1:0] tcp_port_t;
  typedef logic [`TCP_SEQ_W-1:0]  tcp_seq_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // connection states, as reported in the status register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [3:0] {
    CLOSED       = 4'd0,
    LISTEN       = 4'd1,
    SYN_RCVD     = 4'd2,  // syn+ack header queued, not yet taken.
    SYN_ACK_WAIT = 4'd3,
    ESTABLISHED  = 4'd4,
    FLUSH        = 4'd5,  // waiting for the outgoing buffer to drain.
    FIN_SEND     = 4'd6,
    LAST_ACK     = 4'd7
  } conn_state_e;

  // the two headers the engine can send.
  typedef enum logic {
    EMIT_SYN_ACK = 1'b0,
    EMIT_FIN_ACK = 1'b1
  } emit_kind_e;

endpackage

`default_nettype wire

// File: tcp_srv_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "tcp_srv_cfg.svh"

module tcp_srv_regs (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    wb_cyc,
  input  wire logic                    wb_stb,
  input  wire logic                    wb_we,
  input  wire logic [`WB_ADR_W-1:0]    wb_adr,
  input  wire logic [`WB_DAT_W-1:0]    wb_dat_w,
  input  tcp_srv_pkg::conn_state_e     conn_state,
  output logic      [`WB_DAT_W-1:0]    wb_dat_r,
  output logic                         wb_ack,
  output logic                         listen,
  output logic                         force_dcn,
  output tcp_srv_pkg::tcp_port_t       loc_port,
  output tcp_srv_pkg::tcp_seq_t        isn
);

  logic                 wb_req;
  logic                 wb_wr;
  logic [`WB_DAT_W-1:0] rd_data;

  // a new request is one not already being acknowledged.
  assign wb_req = wb_cyc & wb_stb & ~wb_ack;
  assign wb_wr  = wb_req & wb_we;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_req;  // one cycle, then low again.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register writes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      listen    <= 1'b0;
      force_dcn <= 1'b0;
      loc_port  <= '0;
      isn       <= '0;
    end else if (wb_wr) begin
      case (wb_adr)
        `REG_CTRL: begin
          listen    <= wb_dat_w[`CTRL_LISTEN_BIT];
          force_dcn <= wb_dat_w[`CTRL_FORCE_DCN_BIT];  // stays set until software clears it.
        end
        `REG_LOC_PORT: loc_port <= wb_dat_w[`TCP_PORT_W-1:0];
        `REG_ISN:      isn      <= wb_dat_w[`TCP_SEQ_W-1:0];
        default: ;  // status and unmapped addresses ignore writes.
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register reads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    rd_data = '0;
    case (wb_adr)
      `REG_CTRL: begin
        rd_data[`CTRL_LISTEN_BIT]    = listen;
        rd_data[`CTRL_FORCE_DCN_BIT] = force_dcn;
      end
      `REG_LOC_PORT: rd_data[`TCP_PORT_W-1:0] = loc_port;
      `REG_ISN:      rd_data[`TCP_SEQ_W-1:0]  = isn;
      `REG_STATUS:   rd_data[3:0]             = conn_state;
      default:       rd_data                  = '0;
    endcase
  end

  // read data is captured with the ack, so it is valid while ack is high.
  always_ff @(posedge clk) begin
    if (wb_req) begin
      wb_dat_r <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: tcp_seg_match.sv
`default_nettype none
`timescale 1ns/1ps

module tcp_seg_match (
  input  wire logic                rx_val,
  input  wire logic                rx_syn,
  input  wire logic                rx_ack,
  input  wire logic                rx_fin,
  input  wire logic                rx_rst,
  input  tcp_srv_pkg::tcp_seq_t    rx_seq,
  input  tcp_srv_pkg::tcp_port_t   rx_src_port,
  input  tcp_srv_pkg::tcp_port_t   rx_dst_port,
  input  tcp_srv_pkg::tcp_port_t   loc_port,
  input  tcp_srv_pkg::tcp_port_t   rem_port,
  input  tcp_srv_pkg::tcp_seq_t    rem_seq,
  output logic                     syn_hit,
  output logic                     est_ack_hit,
  output logic                     fin_hit,
  output logic                     rst_hit,
  output logic                     peer_ack_hit
);

  logic to_local;
  logic conn_match;
  logic seq_next;

  assign to_local = rx_val & (rx_dst_port == loc_port);

  // the segment belongs to the recorded connection.
  assign conn_match = to_local & (rx_src_port == rem_port);

  // the third handshake step carries the peer's sequence plus one.
  assign seq_next = (rx_seq == rem_seq + tcp_srv_pkg::tcp_seq_t'(1));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // hit outputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign syn_hit      = to_local & rx_syn;  // any source port may open.
  assign est_ack_hit  = conn_match & rx_ack & seq_next;
  assign fin_hit      = conn_match & rx_fin;
  assign rst_hit      = conn_match & rx_rst;
  assign peer_ack_hit = conn_match & rx_ack;

endmodule

`default_nettype wire

// File: tcp_conn_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module tcp_conn_fsm (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     listen,
  input  wire logic                     force_dcn,
  input  tcp_srv_pkg::tcp_seq_t         isn,
  input  wire logic                     syn_hit,
  input  wire logic                     est_ack_hit,
  input  wire logic                     fin_hit,
  input  wire logic                     rst_hit,
  input  wire logic                     peer_ack_hit,
  input  tcp_srv_pkg::tcp_seq_t         rx_seq,
  input  tcp_srv_pkg::tcp_port_t        rx_src_port,
  input  wire logic                     tx_flushed,
  input  wire logic                     sent,
  output tcp_srv_pkg::conn_state_e      state,
  output tcp_srv_pkg::tcp_port_t        rem_port,
  output tcp_srv_pkg::tcp_seq_t         rem_seq,
  output logic                          emit,
  output tcp_srv_pkg::emit_kind_e       emit_kind,
  output tcp_srv_pkg::tcp_seq_t         emit_seq,
  output tcp_srv_pkg::tcp_seq_t         emit_ack
);

  tcp_srv_pkg::tcp_seq_t loc_seq;
  logic                  rst_cause;  // close was caused by a peer reset.
  logic                  fin_cause;
  logic                  take_syn;
  logic                  open_done;
  logic                  close_req;
  logic                  start_fin;

  assign take_syn  = (state == tcp_srv_pkg::LISTEN) & listen & syn_hit;
  assign open_done = (state == tcp_srv_pkg::SYN_ACK_WAIT) & est_ack_hit;
  assign close_req = ~listen | force_dcn | fin_hit | rst_hit;
  assign start_fin = (state == tcp_srv_pkg::FLUSH) & tx_flushed & ~rst_cause;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= tcp_srv_pkg::CLOSED;
      emit      <= 1'b0;
      rst_cause <= 1'b0;
      fin_cause <= 1'b0;
    end else begin
      emit <= take_syn | start_fin;  // one pulse on entry to SYN_RCVD or FIN_SEND.
      case (state)
        tcp_srv_pkg::CLOSED: begin
          if (listen) state <= tcp_srv_pkg::LISTEN;
        end
        tcp_srv_pkg::LISTEN: begin
          if (!listen) begin
            state <= tcp_srv_pkg::CLOSED;
          end else if (syn_hit) begin
            state <= tcp_srv_pkg::SYN_RCVD;
          end
        end
        tcp_srv_pkg::SYN_RCVD: begin
          if (sent) state <= tcp_srv_pkg::SYN_ACK_WAIT;
        end
        tcp_srv_pkg::SYN_ACK_WAIT: begin
          if (est_ack_hit) state <= tcp_srv_pkg::ESTABLISHED;
        end
        tcp_srv_pkg::ESTABLISHED: begin
          if (close_req) begin
            state     <= tcp_srv_pkg::FLUSH;
            rst_cause <= rst_hit;
            fin_cause <= fin_hit & ~rst_hit;
          end
        end
        tcp_srv_pkg::FLUSH: begin
          // a reset closes silently, anything else sends our fin.
          if (tx_flushed) begin
            state <= rst_cause ? tcp_srv_pkg::CLOSED : tcp_srv_pkg::FIN_SEND;
          end
        end
        tcp_srv_pkg::FIN_SEND: begin
          if (sent) state <= tcp_srv_pkg::LAST_ACK;
        end
        tcp_srv_pkg::LAST_ACK: begin
          if (peer_ack_hit) state <= tcp_srv_pkg::CLOSED;
        end
        default: state <= tcp_srv_pkg::CLOSED;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // connection record and outgoing header values
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (take_syn) begin
      rem_port  <= rx_src_port;
      rem_seq   <= rx_seq;
      loc_seq   <= isn;
      emit_kind <= tcp_srv_pkg::EMIT_SYN_ACK;
      emit_seq  <= isn;
      emit_ack  <= rx_seq + tcp_srv_pkg::tcp_seq_t'(1);
    end
    if (open_done) begin
      loc_seq <= loc_seq + tcp_srv_pkg::tcp_seq_t'(1);  // our syn used one number.
    end
    if (start_fin) begin
      emit_kind <= tcp_srv_pkg::EMIT_FIN_ACK;
      emit_seq  <= loc_seq;
      // a peer fin takes one more sequence number than its syn alone.
      emit_ack  <= fin_cause ? rem_seq + tcp_srv_pkg::tcp_seq_t'(2)
                             : rem_seq + tcp_srv_pkg::tcp_seq_t'(1);
    end
  end

endmodule

`default_nettype wire

// File: tcp_tx_hdr.sv
`default_nettype none
`timescale 1ns/1ps

module tcp_tx_hdr (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  emit,
  input  tcp_srv_pkg::emit_kind_e    emit_kind,
  input  tcp_srv_pkg::tcp_seq_t      emit_seq,
  input  tcp_srv_pkg::tcp_seq_t      emit_ack,
  input  tcp_srv_pkg::tcp_port_t     loc_port,
  input  tcp_srv_pkg::tcp_port_t     rem_port,
  input  wire logic                  tx_acc,
  output logic                       sent,
  output logic                       tx_val,
  output logic                       tx_syn,
  output logic                       tx_ack,
  output logic                       tx_fin,
  output logic                       tx_rst,
  output tcp_srv_pkg::tcp_seq_t      tx_seq,
  output tcp_srv_pkg::tcp_seq_t      tx_ack_num,
  output tcp_srv_pkg::tcp_port_t     tx_src_port,
  output tcp_srv_pkg::tcp_port_t     tx_dst_port
);

  logic xfer;

  assign xfer = tx_val & tx_acc;

  // this engine never sends a reset.
  assign tx_rst = 1'b0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_val <= 1'b0;
      sent   <= 1'b0;
    end else begin
      sent <= xfer;  // the fsm moves on one edge after the transfer.
      if (emit) begin
        tx_val <= 1'b1;
      end else if (xfer) begin
        tx_val <= 1'b0;
      end
    end
  end

  // fields load only on emit and hold through back-pressure.
  always_ff @(posedge clk) begin
    if (emit) begin
      tx_syn      <= (emit_kind == tcp_srv_pkg::EMIT_SYN_ACK);
      tx_fin      <= (emit_kind == tcp_srv_pkg::EMIT_FIN_ACK);
      tx_ack      <= 1'b1;  // both headers acknowledge the peer.
      tx_seq      <= emit_seq;
      tx_ack_num  <= emit_ack;
      tx_src_port <= loc_port;
      tx_dst_port <= rem_port;
    end
  end

endmodule

`default_nettype wire

// File: tcp_srv_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "tcp_srv_cfg.svh"

module tcp_srv_top (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  // wishbone slave.
  input  wire logic                   wb_cyc,
  input  wire logic                   wb_stb,
  input  wire logic                   wb_we,
  input  wire logic [`WB_ADR_W-1:0]   wb_adr,
  input  wire logic [`WB_DAT_W-1:0]   wb_dat_w,
  output logic      [`WB_DAT_W-1:0]   wb_dat_r,
  output logic                        wb_ack,
  // received segment headers.
  input  wire logic                   rx_val,
  input  wire logic                   rx_syn,
  input  wire logic                   rx_ack,
  input  wire logic                   rx_fin,
  input  wire logic                   rx_rst,
  input  tcp_srv_pkg::tcp_seq_t       rx_seq,
  input  tcp_srv_pkg::tcp_seq_t       rx_ack_num,
  input  tcp_srv_pkg::tcp_port_t      rx_src_port,
  input  tcp_srv_pkg::tcp_port_t      rx_dst_port,
  input  wire logic                   tx_flushed,
  // outgoing headers.
  output logic                        tx_val,
  output logic                        tx_syn,
  output logic                        tx_ack,
  output logic                        tx_fin,
  output logic                        tx_rst,
  output tcp_srv_pkg::tcp_seq_t       tx_seq,
  output tcp_srv_pkg::tcp_seq_t       tx_ack_num,
  output tcp_srv_pkg::tcp_port_t      tx_src_port,
  output tcp_srv_pkg::tcp_port_t      tx_dst_port,
  input  wire logic                   tx_acc
);

  logic                     listen;
  logic                     force_dcn;
  tcp_srv_pkg::tcp_port_t   loc_port;
  tcp_srv_pkg::tcp_seq_t    isn;
  tcp_srv_pkg::conn_state_e conn_state;
  tcp_srv_pkg::tcp_port_t   rem_port;
  tcp_srv_pkg::tcp_seq_t    rem_seq;
  logic                     syn_hit;
  logic                     est_ack_hit;
  logic                     fin_hit;
  logic                     rst_hit;
  logic                     peer_ack_hit;
  logic                     emit;
  tcp_srv_pkg::emit_kind_e  emit_kind;
  tcp_srv_pkg::tcp_seq_t    emit_seq;
  tcp_srv_pkg::tcp_seq_t    emit_ack;
  logic                     sent;

  tcp_srv_regs u_regs (
    .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
    .conn_state, .wb_dat_r, .wb_ack, .listen, .force_dcn, .loc_port, .isn
  );

  // the ack number field is not checked by this engine.
  tcp_seg_match u_match (
    .rx_val, .rx_syn, .rx_ack, .rx_fin, .rx_rst, .rx_seq, .rx_src_port, .rx_dst_port,
    .loc_port, .rem_port, .rem_seq,
    .syn_hit, .est_ack_hit, .fin_hit, .rst_hit, .peer_ack_hit
  );

  tcp_conn_fsm u_fsm (
    .clk, .rst_n, .listen, .force_dcn, .isn,
    .syn_hit, .est_ack_hit, .fin_hit, .rst_hit, .peer_ack_hit,
    .rx_seq, .rx_src_port, .tx_flushed, .sent,
    .state (conn_state),
    .rem_port, .rem_seq, .emit, .emit_kind, .emit_seq, .emit_ack
  );

  tcp_tx_hdr u_tx (
    .clk, .rst_n, .emit, .emit_kind, .emit_seq, .emit_ack, .loc_port, .rem_port, .tx_acc,
    .sent, .tx_val, .tx_syn, .tx_ack, .tx_fin, .tx_rst, .tx_seq, .tx_ack_num,
    .tx_src_port, .tx_dst_port
  );

endmodule

`default_nettype wire

// File: tb_tcp_srv.sv
`default_nettype none
`timescale 1ns/1ps

`include "tcp_srv_cfg.svh"

module tb_tcp_srv;

  localparam int MAX_CYCLES = 2000;  // six tests, each well under 150 cycles.

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   wb_cyc, wb_stb, wb_we, wb_ack;
  logic [`WB_ADR_W-1:0]   wb_adr;
  logic [`WB_DAT_W-1:0]   wb_dat_w, wb_dat_r;
  logic                   rx_val, rx_syn, rx_ack, rx_fin, rx_rst, tx_flushed, tx_acc;
  logic                   tx_val, tx_syn, tx_ack, tx_fin, tx_rst;
  tcp_srv_pkg::tcp_seq_t  rx_seq, rx_ack_num, tx_seq, tx_ack_num;
  tcp_srv_pkg::tcp_port_t rx_src_port, rx_dst_port, tx_src_port, tx_dst_port;

  // the last outgoing header, as seen while tx_val was high.
  logic                   cap_syn, cap_ack, cap_fin, cap_rst;
  tcp_srv_pkg::tcp_seq_t  cap_seq, cap_ack_num;
  tcp_srv_pkg::tcp_port_t cap_src, cap_dst;

  tcp_srv_pkg::tcp_port_t loc_port;
  tcp_srv_pkg::tcp_seq_t  isn;
  tcp_srv_pkg::tcp_port_t peer_port;
  tcp_srv_pkg::tcp_seq_t  peer_seq;
  integer                 seed;
  int                     errors;
  int                     failed_tests;
  int                     cycles = 0;

  tcp_srv_top dut (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_state(input tcp_srv_pkg::conn_state_e got, exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic check_seq(input tcp_srv_pkg::tcp_seq_t got, exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_port(input tcp_srv_pkg::tcp_port_t got, exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input logic got, exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus and segment drivers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic wb_cycle(input logic we, input logic [`WB_ADR_W-1:0] adr,
                          input logic [`WB_DAT_W-1:0] wdata,
                          output logic [`WB_DAT_W-1:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && waited < 8);
    if (!wb_ack) begin
      $display("error at %0t: no wishbone ack for address %h", $time, adr);
      errors++;
    end
    rdata = wb_dat_r;  // valid while ack is high.
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic wb_write(input logic [`WB_ADR_W-1:0] adr, input logic [`WB_DAT_W-1:0] data);
    logic [`WB_DAT_W-1:0] unused;
    wb_cycle(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [`WB_ADR_W-1:0] adr, output logic [`WB_DAT_W-1:0] data);
    wb_cycle(1'b0, adr, '0, data);
  endtask

  task automatic check_status(input tcp_srv_pkg::conn_state_e exp, input string what);
    logic [`WB_DAT_W-1:0] data;
    wb_read(`REG_STATUS, data);
    check_state(tcp_srv_pkg::conn_state_e'(data[3:0]), exp, what);
  endtask

  task automatic send_seg(input logic syn, ack, fin, rst, input tcp_srv_pkg::tcp_seq_t seq,
                          input tcp_srv_pkg::tcp_port_t src, dst);
    @(posedge clk);
    rx_val      <= 1'b1;
    rx_syn      <= syn;
    rx_ack      <= ack;
    rx_fin      <= fin;
    rx_rst      <= rst;
    rx_seq      <= seq;
    rx_src_port <= src;
    rx_dst_port <= dst;
    @(posedge clk);
    rx_val <= 1'b0;
  endtask

  // captures the next header and, if tx_acc is high, returns after its transfer edge.
  task automatic wait_tx();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!tx_val && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (!tx_val) begin
      $display("error at %0t: no outgoing header within 20 cycles", $time);
      errors++;
    end
    cap_syn     = tx_syn;
    cap_ack     = tx_ack;
    cap_fin     = tx_fin;
    cap_rst     = tx_rst;
    cap_seq     = tx_seq;
    cap_ack_num = tx_ack_num;
    cap_src     = tx_src_port;
    cap_dst     = tx_dst_port;
    if (tx_acc) @(posedge clk);
  endtask

  task automatic check_hdr(input logic syn, fin, input tcp_srv_pkg::tcp_seq_t seq, ack_num,
                           input tcp_srv_pkg::tcp_port_t src, dst);
    check_bit(cap_syn, syn, "tx_syn");
    check_bit(cap_ack, 1'b1, "tx_ack");
    check_bit(cap_fin, fin, "tx_fin");
    check_bit(cap_rst, 1'b0, "tx_rst");
    check_seq(cap_seq, seq, "tx_seq");
    check_seq(cap_ack_num, ack_num, "tx_ack_num");
    check_port(cap_src, src, "tx_src_port");
    check_port(cap_dst, dst, "tx_dst_port");
  endtask

  task automatic new_peer();
    logic [31:0] r;
    r         = $random(seed);
    peer_port = r[`TCP_PORT_W-1:0];
    peer_seq  = $random(seed);
  endtask

  // full passive open with a fresh peer.
  task automatic open_conn();
    new_peer();
    send_seg(1'b1, 1'b0, 1'b0, 1'b0, peer_seq, peer_port, loc_port);
    wait_tx();
    send_seg(1'b0, 1'b1, 1'b0, 1'b0, peer_seq + 32'd1, peer_port, loc_port);
    check_status(tcp_srv_pkg::ESTABLISHED, "state after open");
  endtask

  task automatic report(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %s: pass", name);
    end else begin
      $display("test %s: fail with %0d errors", name, errors - errs_before);
      failed_tests++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_registers();
    logic [`WB_DAT_W-1:0] data;
    int                   errs;
    errs = errors;
    wb_read(`REG_CTRL, data);
    check_bit(data[`CTRL_LISTEN_BIT], 1'b0, "listen after reset");
    check_bit(data[`CTRL_FORCE_DCN_BIT], 1'b0, "force_dcn after reset");
    wb_read(`REG_LOC_PORT, data);
    check_port(data[`TCP_PORT_W-1:0], '0, "local port after reset");
    wb_read(`REG_ISN, data);
    check_seq(data, '0, "isn after reset");
    check_status(tcp_srv_pkg::CLOSED, "state after reset");
    wb_write(`REG_LOC_PORT, {16'h0, loc_port});
    wb_write(`REG_ISN, isn);
    wb_write(`REG_CTRL, 32'h2);  // force_dcn alone does nothing while closed.
    wb_read(`REG_CTRL, data);
    check_bit(data[`CTRL_LISTEN_BIT], 1'b0, "listen read back");
    check_bit(data[`CTRL_FORCE_DCN_BIT], 1'b1, "force_dcn read back");
    wb_read(`REG_LOC_PORT, data);
    check_port(data[`TCP_PORT_W-1:0], loc_port, "local port read back");
    wb_read(`REG_ISN, data);
    check_seq(data, isn, "isn read back");
    wb_write(`REG_STATUS, 32'hffff_ffff);
    check_status(tcp_srv_pkg::CLOSED, "state after write to status");
    wb_write(`REG_CTRL, 32'h1);
    check_status(tcp_srv_pkg::LISTEN, "state after listen set");
    report("registers", errs);
  endtask

  task automatic test_handshake();
    int errs;
    errs = errors;
    new_peer();
    send_seg(1'b1, 1'b0, 1'b0, 1'b0, peer_seq, peer_port, loc_port ^ 16'h0001);
    check_status(tcp_srv_pkg::LISTEN, "state after syn to another port");
    send_seg(1'b1, 1'b0, 1'b0, 1'b0, peer_seq, peer_port, loc_port);
    wait_tx();
    check_hdr(1'b1, 1'b0, isn, peer_seq + 32'd1, loc_port, peer_port);
    check_status(tcp_srv_pkg::SYN_ACK_WAIT, "state after syn+ack");
    send_seg(1'b0, 1'b1, 1'b0, 1'b0, peer_seq + 32'd1, peer_port, loc_port);
    check_status(tcp_srv_pkg::ESTABLISHED, "state after third ack");
    report("handshake", errs);
  endtask

  task automatic test_peer_fin();
    int errs;
    errs = errors;
    send_seg(1'b0, 1'b1, 1'b1, 1'b0, peer_seq + 32'd1, peer_port, loc_port);
    check_status(tcp_srv_pkg::FLUSH, "state after peer fin");
    repeat (5) @(posedge clk);
    check_status(tcp_srv_pkg::FLUSH, "state while the buffer drains");
    tx_flushed <= 1'b1;
    wait_tx();
    tx_flushed <= 1'b0;
    check_hdr(1'b0, 1'b1, isn + 32'd1, peer_seq + 32'd2, loc_port, peer_port);
    check_status(tcp_srv_pkg::LAST_ACK, "state after fin+ack");
    send_seg(1'b0, 1'b1, 1'b0, 1'b0, peer_seq + 32'd2, peer_port, loc_port);
    check_status(tcp_srv_pkg::LISTEN, "state after the last ack");
    report("peer fin close", errs);
  endtask

  task automatic test_back_pressure();
    int errs;
    errs = errors;
    new_peer();
    tx_acc <= 1'b0;
    send_seg(1'b1, 1'b0, 1'b0, 1'b0, peer_seq, peer_port, loc_port);
    wait_tx();
    repeat (10) begin
      @(negedge clk);
      check_bit(tx_val, 1'b1, "tx_val under back-pressure");
      check_bit(tx_syn, cap_syn, "tx_syn under back-pressure");
      check_bit(tx_ack, cap_ack, "tx_ack under back-pressure");
      check_bit(tx_fin, cap_fin, "tx_fin under back-pressure");
      check_bit(tx_rst, cap_rst, "tx_rst under back-pressure");
      check_seq(tx_seq, cap_seq, "tx_seq under back-pressure");
      check_seq(tx_ack_num, cap_ack_num, "tx_ack_num under back-pressure");
      check_port(tx_src_port, cap_src, "tx_src_port under back-pressure");
      check_port(tx_dst_port, cap_dst, "tx_dst_port under back-pressure");
    end
    check_hdr(1'b1, 1'b0, isn, peer_seq + 32'd1, loc_port, peer_port);
    check_status(tcp_srv_pkg::SYN_RCVD, "state under back-pressure");
    tx_acc <= 1'b1;
    @(posedge clk);
    check_status(tcp_srv_pkg::SYN_ACK_WAIT, "state after the held header left");
    send_seg(1'b0, 1'b1, 1'b0, 1'b0, peer_seq + 32'd2, peer_port, loc_port);
    check_status(tcp_srv_pkg::SYN_ACK_WAIT, "state after ack with wrong seq");
    send_seg(1'b0, 1'b1, 1'b0, 1'b0, peer_seq + 32'd1, peer_port, loc_port);
    check_status(tcp_srv_pkg::ESTABLISHED, "state after correct ack");
    report("back-pressure", errs);
  endtask

  task automatic test_peer_rst();
    int errs;
    errs = errors;
    send_seg(1'b0, 1'b0, 1'b0, 1'b1, peer_seq + 32'd1, peer_port ^ 16'h0001, loc_port);
    check_status(tcp_srv_pkg::ESTABLISHED, "state after reset from another port");
    send_seg(1'b0, 1'b0, 1'b0, 1'b1, peer_seq + 32'd1, peer_port, loc_port);
    check_status(tcp_srv_pkg::FLUSH, "state after peer reset");
    tx_flushed <= 1'b1;
    repeat (10) begin
      @(negedge clk);
      check_bit(tx_val, 1'b0, "tx_val after reset close");  // the close is silent.
    end
    @(posedge clk);
    tx_flushed <= 1'b0;
    check_status(tcp_srv_pkg::LISTEN, "state after reset close");
    report("peer reset", errs);
  endtask

  task automatic test_local_close();
    int errs;
    errs = errors;
    tx_flushed <= 1'b1;
    open_conn();
    wb_write(`REG_CTRL, 32'h3);
    wait_tx();
    check_hdr(1'b0, 1'b1, isn + 32'd1, peer_seq + 32'd1, loc_port, peer_port);
    wb_write(`REG_CTRL, 32'h1);
    check_status(tcp_srv_pkg::LAST_ACK, "state after forced fin+ack");
    send_seg(1'b0, 1'b1, 1'b0, 1'b0, peer_seq + 32'd1, peer_port, loc_port);
    check_status(tcp_srv_pkg::LISTEN, "state after forced close");
    open_conn();
    wb_write(`REG_CTRL, 32'h0);
    wait_tx();
    check_hdr(1'b0, 1'b1, isn + 32'd1, peer_seq + 32'd1, loc_port, peer_port);
    check_status(tcp_srv_pkg::LAST_ACK, "state after listen dropped");
    send_seg(1'b0, 1'b1, 1'b0, 1'b0, peer_seq + 32'd1, peer_port, loc_port);
    check_status(tcp_srv_pkg::CLOSED, "state after close with listen dropped");
    tx_flushed <= 1'b0;
    report("local close", errs);
  endtask

  initial begin
    seed         = 32'hf604_53bd;
    errors       = 0;
    failed_tests = 0;
    loc_port     = 16'h1f90;
    isn          = 32'hfedc_ba98;
    rst_n       <= 1'b0;
    wb_cyc      <= 1'b0;
    wb_stb      <= 1'b0;
    wb_we       <= 1'b0;
    wb_adr      <= '0;
    wb_dat_w    <= '0;
    rx_val      <= 1'b0;
    rx_syn      <= 1'b0;
    rx_ack      <= 1'b0;
    rx_fin      <= 1'b0;
    rx_rst      <= 1'b0;
    rx_seq      <= '0;
    rx_ack_num  <= '0;
    rx_src_port <= '0;
    rx_dst_port <= '0;
    tx_flushed  <= 1'b0;
    tx_acc      <= 1'b1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    test_registers();
    test_handshake();
    test_peer_fin();  // closes the connection opened by the handshake test.
    test_back_pressure();
    test_peer_rst();
    test_local_close();
    $display("tests run 6, tests failed %0d, errors %0d", failed_tests, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tcp_srv_top.f
+incdir+.
tcp_srv_pkg.sv
tcp_srv_regs.sv
tcp_seg_match.sv
tcp_conn_fsm.sv
tcp_tx_hdr.sv
tcp_srv_top.sv
tb_tcp_srv.sv

// File: Makefile
# Verilator flow for the tcp server engine and its testbench.

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tcp_srv_top.f --top-module tcp_srv_top
	verilator --lint-only --timing -f tcp_srv_top.f --top-module tb_tcp_srv

sim:
	verilator --binary --timing -f tcp_srv_top.f --top-module tb_tcp_srv -o tb_tcp_srv
	./obj_dir/tb_tcp_srv > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
